/* design/gba_loader_pkg.sv */
// ==============================
// Shared widths, host indexes, ROM offset,
// flash tag, quirk table and arbiter states
// ==============================

package gba_loader_pkg;

	// Host download channel
	typedef logic [26:0]  ioctl_addr_t;  // Byte address
	typedef logic [15:0]  ioctl_data_t;
	typedef logic [7:0]   ioctl_index_t;

	// External memory port, halfword addressed
	typedef logic [25:0]  mem_addr_t;
	typedef logic [63:0]  mem_rdata_t;   // Two dwords per read
	typedef logic [31:0]  dword_t;
	typedef logic [23:0]  rom_addr_t;    // Core side dword address
	typedef logic [11:0]  bios_addr_t;

	typedef logic [127:0] cheat_code_t;  // Flags, address, compare, replace
	typedef logic [95:0]  cart_title_t;
	typedef logic [1:0]   cart_type_t;
	typedef logic [4:0]   quirk_set_t;

	localparam ioctl_index_t INDEX_BIOS  = 8'd0;
	localparam ioctl_index_t INDEX_CHEAT = 8'd255;

	localparam mem_addr_t ROM_START_HW = 26'd393216; // Byte offset 786432

	// Header line 0xA0..0xAF, title in its first 12 bytes
	localparam logic [22:0] TITLE_LINE     = 23'hA;
	localparam logic [3:0]  TITLE_DONE_OFS = 4'd12;

	localparam logic [71:0] FLASH1M_TAG = "FLASH1M_V";

	// Bit positions inside quirk_set_t
	localparam int QUIRK_SRAM  = 0;
	localparam int QUIRK_REMAP = 1;
	localparam int QUIRK_GPIO  = 2;
	localparam int QUIRK_TILT  = 3;
	localparam int QUIRK_SOLAR = 4;

	localparam int QUIRK_COUNT = 8;

	localparam cart_title_t QUIRK_TITLES [QUIRK_COUNT] = '{
		"ROCKY BOXING",
		"DBZ LGCYGOKU",
		{"SUPER MARIO", 8'h00},
		{"ZELDA 1", 40'h00_0000_0000},
		"POKEMON EMER",
		{"BOKTAI", 48'h0000_0000_0000},
		"HAPPYPANECHU",
		{"YOSHI TOPSY", 8'h00}
	};

	localparam quirk_set_t QUIRK_SETS [QUIRK_COUNT] = '{
		5'b00001, // SRAM off
		5'b00001,
		5'b00011, // Classic NES titles also remap
		5'b00011,
		5'b00100, // RTC over GPIO
		5'b10100, // GPIO plus light sensor
		5'b01000, // Tilt sensor
		5'b01000
	};

	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_LOAD,
		ARB_READ
	} arb_state_t;

endpackage

/* design/download_router.sv */
// ==============================
// Download sorting by index, BIOS dword
// pairing and cheat code assembly
// ==============================
`timescale 1ns/1ps

module download_router (
	input  logic                          clk_sys,
	input  logic                          reset,
	input  logic                          ioctl_download,
	input  gba_loader_pkg::ioctl_index_t  ioctl_index,
	input  gba_loader_pkg::ioctl_addr_t   ioctl_addr,
	input  gba_loader_pkg::ioctl_data_t   ioctl_dout,
	input  logic                          ioctl_wr,
	input  logic                          homebrew_bios,  // Own BIOS in use, keep RAM untouched
	output logic                          cart_download,
	output gba_loader_pkg::bios_addr_t    bios_wraddr,
	output gba_loader_pkg::dword_t        bios_wrdata,
	output logic                          bios_wr,
	output gba_loader_pkg::cheat_code_t   gg_code,
	output logic                          gg_valid,
	output logic                          gg_reset
);
	import gba_loader_pkg::*;

	logic bios_download;
	logic code_download;
	logic code_download_d; // Start of a cheat list
	logic bios_take;       // BIOS half-word accepted this cycle

	assign bios_take = bios_download & ioctl_wr & ~homebrew_bios;

	// ==============================
	// Stream flags and strobes
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_download   <= 1'b0;
			bios_download   <= 1'b0;
			code_download   <= 1'b0;
			code_download_d <= 1'b0;
			bios_wr         <= 1'b0;
			gg_valid        <= 1'b0;
			gg_reset        <= 1'b0;
		end else begin
			// Every index other than BIOS and cheats is a cartridge image
			cart_download   <= ioctl_download & (ioctl_index != INDEX_BIOS) &
				(ioctl_index != INDEX_CHEAT);
			bios_download   <= ioctl_download & (ioctl_index == INDEX_BIOS);
			code_download   <= ioctl_download & (ioctl_index == INDEX_CHEAT);
			code_download_d <= code_download;

			bios_wr  <= bios_take & ioctl_addr[1];                             // High half completes dword
			gg_valid <= code_download & ioctl_wr & (ioctl_addr[3:0] == 4'd14); // Last word of record
			gg_reset <= code_download & ~code_download_d;                      // Old codes dropped
		end
	end

	// BIOS words arrive low half first
	always_ff @(posedge clk_sys) begin
		if (bios_take) begin
			if (!ioctl_addr[1]) begin
				bios_wrdata[15:0] <= ioctl_dout;
			end else begin
				bios_wrdata[31:16] <= ioctl_dout;
				bios_wraddr        <= ioctl_addr[13:2];
			end
		end
	end

	// ==============================
	// Cheat record, 16 bytes each
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (code_download & ioctl_wr) begin
			case (ioctl_addr[3:0])
				4'd0:  gg_code[111:96]  <= ioctl_dout; // Flags low
				4'd2:  gg_code[127:112] <= ioctl_dout; // Flags high
				4'd4:  gg_code[79:64]   <= ioctl_dout; // Address low
				4'd6:  gg_code[95:80]   <= ioctl_dout;
				4'd8:  gg_code[47:32]   <= ioctl_dout; // Compare value
				4'd10: gg_code[63:48]   <= ioctl_dout;
				4'd12: gg_code[15:0]    <= ioctl_dout; // Replace value
				4'd14: gg_code[31:16]   <= ioctl_dout;
				default: ;                              // Odd offsets never written
			endcase
		end
	end

endmodule

/* design/cart_header_scan.sv */
// ==============================
// Cartridge header scan: flash tag, title
// quirk lookup, type, size and loaded flag
// ==============================
`timescale 1ns/1ps

module cart_header_scan (
	input  logic                          clk_sys,
	input  logic                          reset,
	input  logic                          cart_download,
	input  gba_loader_pkg::ioctl_index_t  ioctl_index,
	input  gba_loader_pkg::ioctl_addr_t   ioctl_addr,
	input  gba_loader_pkg::ioctl_data_t   ioctl_dout,
	input  logic                          ioctl_wr,
	output gba_loader_pkg::cart_type_t    cart_type,
	output logic                          cart_loaded,
	output logic                          flash_1m,
	output gba_loader_pkg::ioctl_addr_t   last_addr,
	output logic                          sram_quirk,
	output logic                          memory_remap_quirk,
	output logic                          gpio_quirk,
	output logic                          tilt_quirk,
	output logic                          solar_quirk
);
	import gba_loader_pkg::*;

	logic        old_download;
	logic        cart_wr;      // Cartridge word this cycle
	logic        title_line;   // Word lies in the header title line
	logic [63:0] str;          // Last eight bytes, oldest on top
	cart_title_t cart_id;
	quirk_set_t  quirk_hit;    // Table match for the current title
	quirk_set_t  quirks;

	assign cart_wr    = cart_download & ioctl_wr;
	assign title_line = (ioctl_addr[26:4] == TITLE_LINE);

	// ==============================
	// Quirk table lookup
	// ==============================
	always_comb begin
		quirk_hit = '0;
		for (int i = 0; i < QUIRK_COUNT; i++) begin
			if (cart_id == QUIRK_TITLES[i])
				quirk_hit = quirk_hit | QUIRK_SETS[i];
		end
	end

	// Status flags, cleared at every new image
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_download <= 1'b0;
			cart_type    <= '0;
			cart_loaded  <= 1'b0;
			flash_1m     <= 1'b0;
			quirks       <= '0;
		end else begin
			old_download <= cart_download;

			if (~old_download & cart_download) begin
				flash_1m    <= 1'b0;
				quirks      <= '0;
				cart_type   <= ioctl_index[7:6]; // Top index bits select the cart kind
				cart_loaded <= 1'b1;
			end

			if (cart_wr) begin
				// Tag may end on the low or the high byte of a word
				if ({str, ioctl_dout[7:0]} == FLASH1M_TAG)
					flash_1m <= 1'b1;
				if ({str[55:0], ioctl_dout[7:0], ioctl_dout[15:8]} == FLASH1M_TAG)
					flash_1m <= 1'b1;

				if (title_line && ioctl_addr[3:0] == TITLE_DONE_OFS)
					quirks <= quirk_hit; // Title complete by now
			end
		end
	end

	// ==============================
	// Byte history, title and image size
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (old_download & ~cart_download)
			last_addr <= ioctl_addr; // Final address of the image

		if (cart_wr) begin
			str <= {str[47:0], ioctl_dout[7:0], ioctl_dout[15:8]};

			// First title character goes to the top byte
			if (title_line && ioctl_addr[3:0] < TITLE_DONE_OFS)
				cart_id[{4'd10 - ioctl_addr[3:0], 3'd0} +: 16] <=
					{ioctl_dout[7:0], ioctl_dout[15:8]};
		end
	end

	assign sram_quirk         = quirks[QUIRK_SRAM];
	assign memory_remap_quirk = quirks[QUIRK_REMAP];
	assign gpio_quirk         = quirks[QUIRK_GPIO];
	assign tilt_quirk         = quirks[QUIRK_TILT];
	assign solar_quirk        = quirks[QUIRK_SOLAR];

endmodule

/* design/rom_load_port.sv */
// ==============================
// Cartridge word write requests and host wait
// ==============================
`timescale 1ns/1ps

module rom_load_port (
	input  logic                         clk_sys,
	input  logic                         reset,
	input  logic                         cart_download,
	input  gba_loader_pkg::ioctl_addr_t  ioctl_addr,
	input  gba_loader_pkg::ioctl_data_t  ioctl_dout,
	input  logic                         ioctl_wr,
	input  logic                         load_ack,
	output logic                         load_req,
	output gba_loader_pkg::mem_addr_t    load_addr,
	output gba_loader_pkg::ioctl_data_t  load_data,
	output logic                         ioctl_wait
);
	import gba_loader_pkg::*;

	logic pending; // One word in flight towards memory

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pending <= 1'b0;
		end else if (cart_download & ioctl_wr) begin
			pending <= 1'b1;
		end else if (load_ack) begin
			pending <= 1'b0;      // Word now in memory
		end
	end

	// Word and target address, held until acked
	always_ff @(posedge clk_sys) begin
		if (cart_download & ioctl_wr) begin
			load_addr <= ROM_START_HW + ioctl_addr[26:1]; // Byte to halfword
			load_data <= ioctl_dout;
		end
	end

	// Host stalls for as long as the word waits
	assign load_req   = pending;
	assign ioctl_wait = pending;

endmodule

/* design/rom_read_port.sv */
// ==============================
// Core ROM read request holding and dword return
// ==============================
`timescale 1ns/1ps

module rom_read_port (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        rom_rd,
	input  gba_loader_pkg::rom_addr_t   rom_addr,
	input  logic                        read_ack,
	input  gba_loader_pkg::mem_rdata_t  read_data,
	output logic                        read_req,
	output gba_loader_pkg::mem_addr_t   read_addr,
	output logic                        rom_done,
	output gba_loader_pkg::dword_t      rom_dword1,
	output gba_loader_pkg::dword_t      rom_dword2
);
	import gba_loader_pkg::*;

	// Request stays up until served; it also blocks new reads
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			read_req <= 1'b0;
			rom_done <= 1'b0;
		end else begin
			rom_done <= read_ack;           // Data lands with the ack
			if (read_ack)
				read_req <= 1'b0;
			else if (rom_rd & ~read_req)
				read_req <= 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rom_rd & ~read_req)
			read_addr <= {1'b0, rom_addr, 1'b0}; // Dword to halfword address

		// First dword low, prefetch dword high
		if (read_ack) begin
			rom_dword1 <= read_data[31:0];
			rom_dword2 <= read_data[63:32];
		end
	end

endmodule

/* design/mem_arbiter.sv */
// ==============================
// Single memory port arbiter, loader first
// ==============================
`timescale 1ns/1ps

module mem_arbiter (
	input  logic                         clk_sys,
	input  logic                         reset,
	input  logic                         load_req,
	input  gba_loader_pkg::mem_addr_t    load_addr,
	input  gba_loader_pkg::ioctl_data_t  load_data,
	input  logic                         read_req,
	input  gba_loader_pkg::mem_addr_t    read_addr,
	input  logic                         mem_ready,
	input  gba_loader_pkg::mem_rdata_t   mem_rdata,
	output logic                         load_ack,
	output logic                         read_ack,
	output gba_loader_pkg::mem_rdata_t   read_data,
	output logic                         mem_req,
	output gba_loader_pkg::mem_addr_t    mem_addr,
	output logic                         mem_we,
	output gba_loader_pkg::ioctl_data_t  mem_wdata
);
	import gba_loader_pkg::*;

	arb_state_t state;
	logic       load_pend; // Requests not already being acked
	logic       read_pend;

	// A peer drops its request only the cycle after its ack
	assign load_pend = load_req & ~load_ack;
	assign read_pend = read_req & ~read_ack;

	// ==============================
	// Grant FSM
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state    <= ARB_IDLE;
			mem_req  <= 1'b0;
			load_ack <= 1'b0;
			read_ack <= 1'b0;
		end else begin
			mem_req  <= 1'b0;
			load_ack <= 1'b0;
			read_ack <= 1'b0;
			case (state)
				ARB_IDLE: begin
					if (load_pend) begin
						mem_req <= 1'b1; // Fixed priority to the loader
						state   <= ARB_LOAD;
					end else if (read_pend) begin
						mem_req <= 1'b1;
						state   <= ARB_READ;
					end
				end
				ARB_LOAD: if (mem_ready) begin
					load_ack <= 1'b1;
					state    <= ARB_IDLE;
				end
				ARB_READ: if (mem_ready) begin
					read_ack <= 1'b1;
					state    <= ARB_IDLE;
				end
				default: state <= ARB_IDLE;
			endcase
		end
	end

	// Access fields follow the grant
	always_ff @(posedge clk_sys) begin
		if (state == ARB_IDLE) begin
			mem_addr  <= load_pend ? load_addr : read_addr;
			mem_we    <= load_pend;
			mem_wdata <= load_data;
		end
		if (state == ARB_READ && mem_ready)
			read_data <= mem_rdata; // Held for the read port
	end

endmodule

/* design/gba_loader_top.sv */
// ==============================
// Loader top: router, header scan, peers, arbiter
// ==============================
`timescale 1ns/1ps

module gba_loader_top (
	input  logic                          clk_sys,
	input  logic                          reset,
	// Host download
	input  logic                          ioctl_download,
	input  gba_loader_pkg::ioctl_index_t  ioctl_index,
	input  gba_loader_pkg::ioctl_addr_t   ioctl_addr,
	input  gba_loader_pkg::ioctl_data_t   ioctl_dout,
	input  logic                          ioctl_wr,
	output logic                          ioctl_wait,
	input  logic                          homebrew_bios,
	// BIOS RAM and cheats
	output gba_loader_pkg::bios_addr_t    bios_wraddr,
	output gba_loader_pkg::dword_t        bios_wrdata,
	output logic                          bios_wr,
	output gba_loader_pkg::cheat_code_t   gg_code,
	output logic                          gg_valid,
	output logic                          gg_reset,
	// Core ROM reads
	input  logic                          rom_rd,
	input  gba_loader_pkg::rom_addr_t     rom_addr,
	output logic                          rom_done,
	output gba_loader_pkg::dword_t        rom_dword1,
	output gba_loader_pkg::dword_t        rom_dword2,
	// External memory
	output logic                          mem_req,
	output gba_loader_pkg::mem_addr_t     mem_addr,
	output logic                          mem_we,
	output gba_loader_pkg::ioctl_data_t   mem_wdata,
	input  logic                          mem_ready,
	input  gba_loader_pkg::mem_rdata_t    mem_rdata,
	// Cartridge status
	output gba_loader_pkg::cart_type_t    cart_type,
	output logic                          cart_loaded,
	output logic                          flash_1m,
	output gba_loader_pkg::ioctl_addr_t   last_addr,
	output logic                          sram_quirk,
	output logic                          memory_remap_quirk,
	output logic                          gpio_quirk,
	output logic                          tilt_quirk,
	output logic                          solar_quirk
);
	import gba_loader_pkg::*;

	logic        cart_download;
	logic        load_req, load_ack;  // Loader peer
	mem_addr_t   load_addr;
	ioctl_data_t load_data;
	logic        read_req, read_ack;  // Core reader peer
	mem_addr_t   read_addr;
	mem_rdata_t  read_data;

	download_router download_router_inst (
		.clk_sys(clk_sys), .reset(reset),
		.ioctl_download(ioctl_download), .ioctl_index(ioctl_index),
		.ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout), .ioctl_wr(ioctl_wr),
		.homebrew_bios(homebrew_bios), .cart_download(cart_download),
		.bios_wraddr(bios_wraddr), .bios_wrdata(bios_wrdata), .bios_wr(bios_wr),
		.gg_code(gg_code), .gg_valid(gg_valid), .gg_reset(gg_reset)
	);

	cart_header_scan cart_header_scan_inst (
		.clk_sys(clk_sys), .reset(reset),
		.cart_download(cart_download), .ioctl_index(ioctl_index),
		.ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout), .ioctl_wr(ioctl_wr),
		.cart_type(cart_type), .cart_loaded(cart_loaded), .flash_1m(flash_1m),
		.last_addr(last_addr), .sram_quirk(sram_quirk),
		.memory_remap_quirk(memory_remap_quirk), .gpio_quirk(gpio_quirk),
		.tilt_quirk(tilt_quirk), .solar_quirk(solar_quirk)
	);

	rom_load_port rom_load_port_inst (
		.clk_sys(clk_sys), .reset(reset), .cart_download(cart_download),
		.ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout), .ioctl_wr(ioctl_wr),
		.load_ack(load_ack), .load_req(load_req), .load_addr(load_addr),
		.load_data(load_data), .ioctl_wait(ioctl_wait)
	);

	rom_read_port rom_read_port_inst (
		.clk_sys(clk_sys), .reset(reset), .rom_rd(rom_rd), .rom_addr(rom_addr),
		.read_ack(read_ack), .read_data(read_data), .read_req(read_req),
		.read_addr(read_addr), .rom_done(rom_done),
		.rom_dword1(rom_dword1), .rom_dword2(rom_dword2)
	);

	mem_arbiter mem_arbiter_inst (
		.clk_sys(clk_sys), .reset(reset),
		.load_req(load_req), .load_addr(load_addr), .load_data(load_data),
		.read_req(read_req), .read_addr(read_addr),
		.mem_ready(mem_ready), .mem_rdata(mem_rdata),
		.load_ack(load_ack), .read_ack(read_ack), .read_data(read_data),
		.mem_req(mem_req), .mem_addr(mem_addr), .mem_we(mem_we), .mem_wdata(mem_wdata)
	);

endmodule

/* tests/loader_checker.sv */
// ==============================
// Loader checker that watches the DUT, keeps
// reference results and counts failures
// ==============================
`timescale 1ns/1ps

module loader_checker (
	input  logic                          clk_sys,
	input  logic                          reset,
	input  logic                          ioctl_download,
	input  gba_loader_pkg::ioctl_index_t  ioctl_index,
	input  gba_loader_pkg::ioctl_addr_t   ioctl_addr,
	input  gba_loader_pkg::ioctl_data_t   ioctl_dout,
	input  logic                          ioctl_wr,
	input  logic                          ioctl_wait,
	input  logic                          homebrew_bios,
	input  gba_loader_pkg::bios_addr_t    bios_wraddr,
	input  gba_loader_pkg::dword_t        bios_wrdata,
	input  logic                          bios_wr,
	input  gba_loader_pkg::cheat_code_t   gg_code,
	input  logic                          gg_valid,
	input  logic                          gg_reset,
	input  logic                          rom_rd,
	input  gba_loader_pkg::rom_addr_t     rom_addr,
	input  logic                          rom_done,
	input  gba_loader_pkg::dword_t        rom_dword1,
	input  gba_loader_pkg::dword_t        rom_dword2,
	output int                            fail_count
);
	import gba_loader_pkg::*;

	logic [15:0] image [mem_addr_t]; // Cartridge words as the host sent them
	logic [43:0] bios_q [$];         // Expected {address, data}
	cheat_code_t code_q [$];
	logic [43:0] bios_exp;
	cheat_code_t code_exp;
	mem_rdata_t  rd_exp;
	logic [15:0] bios_lo;
	logic [127:0] rec;               // Cheat record with halfword i at bits 16i
	logic        rd_busy;
	rom_addr_t   rd_addr;
	logic        wr_seen;            // Host write in the previous cycle
	logic        wr_cart;            // That write belonged to a cartridge
	int          checks;
	int          test_fails;
	int          gg_reset_count;

	initial begin
		fail_count     = 0;
		checks         = 0;
		test_fails     = 0;
		gg_reset_count = 0;
		rd_busy        = 1'b0;
		wr_seen        = 1'b0;
		wr_cart        = 1'b0;
	end

	// ==============================
	// Reference functions
	// ==============================
	// Flags, address, compare, replace from the top; low half-word first in the stream
	function automatic cheat_code_t cheat_ref(input logic [127:0] r);
		return {r[31:16], r[15:0], r[63:48], r[47:32],
			r[95:80], r[79:64], r[127:112], r[111:96]};
	endfunction

	// Four half-words from the dword address with a zero bit appended
	function automatic mem_rdata_t rom_ref(input rom_addr_t a);
		mem_addr_t hw;
		hw = {1'b0, a, 1'b0};
		return {image[hw + 3], image[hw + 2], image[hw + 1], image[hw]};
	endfunction

	task automatic check_value(input string what, input logic [127:0] got,
		input logic [127:0] exp);
		checks++;
		if (got !== exp) begin
			fail_count++;
			test_fails++;
			$display("[FAIL] %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic report_error(input string msg);
		fail_count++;
		test_fails++;
		$display("Error at %0t ns: %s", $time, msg);
	endtask

	// Leftover entries count as missing pulses
	task automatic end_test(input string name);
		if (bios_q.size() != 0)
			report_error("a BIOS dword was never written");
		if (code_q.size() != 0)
			report_error("a cheat record never produced gg_valid");
		if (rd_busy)
			report_error("a core ROM read never finished");
		bios_q.delete();
		code_q.delete();
		if (test_fails == 0)
			$display("test %s: passed", name);
		else
			$display("test %s: %0d failures", name, test_fails);
		test_fails = 0;
	endtask

	task automatic final_report();
		$display("%0d checks, %0d failures", checks, fail_count);
	endtask

	// ==============================
	// Monitor
	// ==============================
	always @(posedge clk_sys) begin
		if (!reset) begin
			// Wait level answers the host write of the previous cycle
			if (wr_seen)
				check_value("ioctl_wait after write", ioctl_wait, wr_cart);
			wr_seen = ioctl_download && ioctl_wr;
			wr_cart = (ioctl_index != INDEX_BIOS) && (ioctl_index != INDEX_CHEAT);

			// DUT strobes first as they answer writes of earlier cycles
			if (bios_wr) begin
				if (bios_q.size() == 0) begin
					report_error("bios_wr pulsed with no BIOS dword pending");
				end else begin
					bios_exp = bios_q.pop_front();
					check_value("bios_wraddr", bios_wraddr, bios_exp[43:32]);
					check_value("bios_wrdata", bios_wrdata, bios_exp[31:0]);
				end
			end
			if (gg_valid) begin
				if (code_q.size() == 0) begin
					report_error("gg_valid pulsed with no cheat record pending");
				end else begin
					code_exp = code_q.pop_front();
					check_value("gg_code", gg_code, code_exp);
				end
			end
			if (gg_reset)
				gg_reset_count++;
			if (rom_done) begin
				if (!rd_busy) begin
					report_error("rom_done pulsed with no read pending");
				end else begin
					rd_exp = rom_ref(rd_addr);
					check_value("rom_dword1", rom_dword1, rd_exp[31:0]);
					check_value("rom_dword2", rom_dword2, rd_exp[63:32]);
				end
				rd_busy = 1'b0;
			end
			if (rom_rd && !rd_busy) begin
				rd_busy = 1'b1;
				rd_addr = rom_addr;
			end

			// Host stream sorted by index
			if (ioctl_download && ioctl_wr) begin
				if (ioctl_index == 8'd0) begin
					if (!ioctl_addr[1])
						bios_lo = ioctl_dout;
					else if (!homebrew_bios)
						bios_q.push_back({ioctl_addr[13:2], ioctl_dout, bios_lo});
				end else if (ioctl_index == 8'd255) begin
					rec[16 * ioctl_addr[3:1] +: 16] = ioctl_dout;
					if (ioctl_addr[3:0] == 4'd14)
						code_q.push_back(cheat_ref(rec)); // Record complete
				end else begin
					image[ROM_START_HW + ioctl_addr[26:1]] = ioctl_dout;
				end
			end
		end
	end

endmodule

/* tests/tb_gba_loader.sv */
// ==============================
// Loader testbench with clock, reset, host streams,
// core reads and a variable-latency memory
// ==============================
`timescale 1ns/1ps

module tb_gba_loader;
	import gba_loader_pkg::*;

	logic         clk_sys;
	logic         reset;
	logic         ioctl_download;
	ioctl_index_t ioctl_index;
	ioctl_addr_t  ioctl_addr;
	ioctl_data_t  ioctl_dout;
	logic         ioctl_wr;
	logic         ioctl_wait;
	logic         homebrew_bios;
	bios_addr_t   bios_wraddr;
	dword_t       bios_wrdata;
	logic         bios_wr;
	cheat_code_t  gg_code;
	logic         gg_valid;
	logic         gg_reset;
	logic         rom_rd;
	rom_addr_t    rom_addr;
	logic         rom_done;
	dword_t       rom_dword1;
	dword_t       rom_dword2;
	logic         mem_req;
	mem_addr_t    mem_addr;
	logic         mem_we;
	ioctl_data_t  mem_wdata;
	logic         mem_ready;
	mem_rdata_t   mem_rdata;
	cart_type_t   cart_type;
	logic         cart_loaded, flash_1m;
	ioctl_addr_t  last_addr;
	logic         sram_quirk, memory_remap_quirk, gpio_quirk, tilt_quirk, solar_quirk;
	int           fail_count;

	integer      seed;
	logic [7:0]  img [0:511];              // Byte image of the next download
	logic [15:0] mem_model [mem_addr_t];
	logic        mem_busy, mem_we_q;
	mem_addr_t   mem_a_q;
	int          mem_cnt;
	logic        hang;                     // Some wait ran out
	string       hang_msg;
	int          n0;

	logic [95:0] titles [6] = '{"ROCKY BOXING", {"SUPER MARIO", 8'h00}, "POKEMON EMER",
		{"BOKTAI", 48'h0}, {"YOSHI TOPSY", 8'h00}, "TETRIS WORLD"};
	logic [4:0]  quirk_exp [6] = '{5'b00001, 5'b00011, 5'b00100, 5'b10100, 5'b01000, 5'b00000};

	gba_loader_top gba_loader_top_inst (.*);
	loader_checker loader_checker_inst (.*);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	task automatic tick();
		@(posedge clk_sys);
		#10;
	endtask

	// ==============================
	// Memory model
	// ==============================
	function automatic logic [15:0] mem_hw(input mem_addr_t a);
		if (mem_model.exists(a))
			return mem_model[a];
		return a[15:0] ^ {6'd0, a[25:16]} ^ 16'hA5C3; // Unwritten fill
	endfunction

	always begin
		tick();
		mem_ready = 1'b0;
		if (reset) begin
			mem_busy = 1'b0;
		end else begin
			if (mem_busy) begin
				mem_cnt--;
				if (mem_cnt == 0) begin
					mem_ready = 1'b1;
					mem_busy  = 1'b0;
					if (!mem_we_q)
						mem_rdata = {mem_hw(mem_a_q + 3), mem_hw(mem_a_q + 2),
							mem_hw(mem_a_q + 1), mem_hw(mem_a_q)};
				end
			end
			if (mem_req) begin
				mem_busy = 1'b1;
				mem_cnt  = 1 + ({$random(seed)} % 6); // 1 to 6 cycles
				mem_a_q  = mem_addr;
				mem_we_q = mem_we;
				if (mem_we)
					mem_model[mem_addr] = mem_wdata;
			end
		end
	end

	// ==============================
	// Host and core stimulus
	// ==============================
	task automatic fill_random(input int nbytes);
		for (int i = 0; i < nbytes; i++)
			img[i] = $random(seed);
	endtask

	// Places the n bottom characters of s with the first one at pos
	task automatic put_bytes(input int pos, input logic [95:0] s, input int n);
		for (int k = 0; k < n; k++)
			img[pos + k] = s[8 * (n - 1 - k) +: 8];
	endtask

	task automatic send_stream(input ioctl_index_t idx, input ioctl_addr_t base,
		input int nbytes);
		int t;
		ioctl_download = 1'b1;
		ioctl_index    = idx;
		tick();
		for (int i = 0; i < nbytes; i += 2) begin
			ioctl_addr = base + i;
			ioctl_dout = {img[i + 1], img[i]}; // Little endian word
			ioctl_wr   = 1'b1;
			tick();
			ioctl_wr = 1'b0;
			tick();                            // Wait level rises by now
			t = 0;
			while (ioctl_wait && !hang) begin
				tick();
				t++;
				if (t > 50) begin
					hang_msg = "ioctl_wait never fell after a cartridge write";
					hang     = 1'b1;
				end
			end
		end
		ioctl_download = 1'b0;
		repeat (4) tick();                     // Address held while last_addr latches
	endtask

	task automatic check_model(input ioctl_addr_t base, input int nbytes);
		mem_addr_t a;
		for (int i = 0; i < nbytes; i += 2) begin
			a = ROM_START_HW + ((base + i) >> 1);
			loader_checker_inst.check_value("memory word",
				mem_model.exists(a) ? mem_model[a] : 16'hxxxx, {img[i + 1], img[i]});
		end
	endtask

	task automatic core_read(input rom_addr_t a);
		int t;
		rom_addr = a;
		rom_rd   = 1'b1;
		tick();
		rom_rd = 1'b0;
		t = 0;
		while (!rom_done && !hang) begin
			tick();
			t++;
			if (t > 100) begin
				hang_msg = "rom_done never came for a core ROM read";
				hang     = 1'b1;
			end
		end
	endtask

	initial begin
		wait (hang);
		$display("%s", hang_msg);
		$display("TESTBENCH FAILED");
		$finish;
	end

	// ==============================
	// Test sequence
	// ==============================
	initial begin
		seed           = 32'h4fa7_fdf2;
		hang           = 1'b0;
		reset          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index    = '0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		ioctl_wr       = 1'b0;
		homebrew_bios  = 1'b0;
		rom_rd         = 1'b0;
		rom_addr       = '0;
		mem_ready      = 1'b0;
		mem_rdata      = '0;
		repeat (3) @(posedge clk_sys);
		#10;
		reset = 1'b0;
		tick();

		fill_random(256);
		send_stream(8'h41, 27'd0, 256);
		check_model(27'd0, 256);
		loader_checker_inst.check_value("last_addr", last_addr, 27'd254);
		loader_checker_inst.check_value("cart_type", cart_type, 2'd1);
		loader_checker_inst.check_value("cart_loaded", cart_loaded, 1'b1);
		loader_checker_inst.end_test("cartridge load");

		fill_random(256);
		put_bytes(32, "FLASH1M_V", 9);         // Tag starts on an even byte
		send_stream(8'h41, 27'd0, 256);
		loader_checker_inst.check_value("flash_1m even", flash_1m, 1'b1);
		fill_random(256);
		put_bytes(49, "FLASH1M_V", 9);         // Odd byte
		send_stream(8'h41, 27'd0, 256);
		loader_checker_inst.check_value("flash_1m odd", flash_1m, 1'b1);
		fill_random(256);
		send_stream(8'h41, 27'd0, 256);
		loader_checker_inst.check_value("flash_1m untagged", flash_1m, 1'b0);
		loader_checker_inst.end_test("flash tag");

		for (int q = 0; q < 6; q++) begin
			fill_random(192);
			put_bytes(160, titles[q], 12);
			send_stream(8'h41, 27'd0, 192);
			loader_checker_inst.check_value("quirk flags", {solar_quirk, tilt_quirk,
				gpio_quirk, memory_remap_quirk, sram_quirk}, quirk_exp[q]);
		end
		fill_random(192);
		put_bytes(160, "ROCKY BOXING", 12);
		send_stream(8'h41, 27'd0, 192);
		fill_random(64);                       // Too short to reach the title
		send_stream(8'h41, 27'd0, 64);
		loader_checker_inst.check_value("quirks after new download", {solar_quirk,
			tilt_quirk, gpio_quirk, memory_remap_quirk, sram_quirk}, 5'b00000);
		loader_checker_inst.end_test("quirks");

		fill_random(64);
		send_stream(8'd0, 27'd0, 64);
		loader_checker_inst.end_test("bios");
		homebrew_bios = 1'b1;
		send_stream(8'd0, 27'd0, 64);
		homebrew_bios = 1'b0;
		loader_checker_inst.end_test("homebrew bios");

		n0 = loader_checker_inst.gg_reset_count;
		fill_random(48);
		send_stream(8'd255, 27'd0, 48);
		loader_checker_inst.check_value("gg_reset pulses",
			loader_checker_inst.gg_reset_count - n0, 1);
		loader_checker_inst.end_test("cheats");

		fill_random(256);
		send_stream(8'h41, 27'd0, 256);
		check_model(27'd0, 256);
		repeat (4) core_read(24'd196608 + ({$random(seed)} % 63));
		fill_random(256);
		fork
			send_stream(8'h41, 27'h400, 256);
			repeat (6) core_read(24'd196608 + ({$random(seed)} % 63));
		join
		check_model(27'h400, 256);
		loader_checker_inst.end_test("core reads");

		loader_checker_inst.final_report();
		if (fail_count == 0 && !hang)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* flist.f */
design/gba_loader_pkg.sv
design/download_router.sv
design/cart_header_scan.sv
design/rom_load_port.sv
design/rom_read_port.sv
design/mem_arbiter.sv
design/gba_loader_top.sv
tests/loader_checker.sv
tests/tb_gba_loader.sv

/* Bender.yml */
package:
  name: gba_loader

sources:
  - design/gba_loader_pkg.sv
  - design/download_router.sv
  - design/cart_header_scan.sv
  - design/rom_load_port.sv
  - design/rom_read_port.sv
  - design/mem_arbiter.sv
  - design/gba_loader_top.sv
  - target: test
    files:
      - tests/loader_checker.sv
      - tests/tb_gba_loader.sv
